// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_reuse_buffer
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
LOG       ?= sim.log
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard hw/*.sv hw/*.svh dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam time HalfPeriod = 4ns;   // 8 ns clock.

    initial begin
        clk_o = 1'b0;
        forever #(HalfPeriod) clk_o = ~clk_o;
    end

    // reset is held for four rising edges and released on a falling edge.
    initial begin
        rst_no = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: dv/tb_reuse_buffer.sv
`timescale 1ns/1ps
`include "rb_config.svh"

module tb_reuse_buffer;

    localparam int NElems  = `RB_N_ELEMS;
    localparam int NBlocks = `RB_N_BLOCKS;
    localparam int Reads   = `RB_ELEM_READS;

    function automatic int pass_beats(input int nb, input int lo);
        return (nb * NElems + lo + 1) * Reads;
    endfunction

    // six short passes, one long pass and the clear test with its ten aborted beats.
    localparam int TotalBeats    = 6 * pass_beats(2, 2) + pass_beats(6, 1)
                                 + 10 + 2 * pass_beats(1, 3);
    localparam int TimeoutCycles = TotalBeats * 4;

    logic              clk, rst_n, clear;
    rb_pkg::blk_cnt_t  num_blocks;
    rb_pkg::elem_ptr_t leftover;
    logic              in_valid, in_ready, out_valid, out_ready, out_last;
    rb_pkg::block_t    in_block;
    rb_pkg::elem_t     out_elem;

    rb_pkg::elem_t     exp_elem [$];
    logic              exp_last [$];
    logic              exp_bend [$];   // last beat of a block read.
    int                seed;
    int                unread;         // accepted blocks whose read has not completed.
    int                blocks_left;    // blocks of the current pass not yet accepted.
    int                cycle_cnt = 0;
    logic [3:0]        data_tag;

    tb_clk_gen clk_gen0 (.clk_o(clk), .rst_no(rst_n));

    reuse_buffer dut0 (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .clear_i      (clear),
        .num_blocks_i (num_blocks),
        .leftover_i   (leftover),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .in_block_i   (in_block),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .out_elem_o   (out_elem),
        .out_last_o   (out_last)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TimeoutCycles) begin
            fail_run($sformatf("timeout after %0d cycles, the DUT stopped handshaking", cycle_cnt));
        end
    end

    // ************************************************************************
    // reference model
    // ************************************************************************
    function automatic rb_pkg::elem_t elem_value(input int b, input int e);
        return {data_tag, 8'(b), 4'(e)};
    endfunction

    function automatic rb_pkg::block_t block_of(input int b);
        rb_pkg::block_t blk;
        for (int e = 0; e < NElems; e++) begin
            blk[e*`RB_ELEM_W +: `RB_ELEM_W] = elem_value(b, e);   // element 0 in the low bits.
        end
        return blk;
    endfunction

    // a backward pass is the forward pass in fully reversed order.
    task automatic add_pass(input int nb, input int lo, input bit backward);
        int b, e, emax;
        for (int i = 0; i <= nb; i++) begin
            b    = backward ? nb - i : i;
            emax = (b == nb) ? lo : NElems - 1;
            for (int j = 0; j <= emax; j++) begin
                e = backward ? emax - j : j;
                for (int r = 0; r < Reads; r++) begin
                    exp_elem.push_back(elem_value(b, e));
                    exp_last.push_back(i == nb && j == emax);
                    exp_bend.push_back(r == Reads - 1 && j == emax);
                end
            end
        end
    endtask

    // ************************************************************************
    // traffic and checks
    // ************************************************************************
    // each loop is one cycle. Inputs change on the falling edge and handshakes
    // are sampled at the rising edge.
    task automatic run_traffic(input int n_blocks, input int n_beats, input bit rand_gap,
                               input bit rand_ready);
        int            sent, beats, gap;
        bit            in_acc, out_acc, bend, held, expect_valid;
        rb_pkg::elem_t held_elem;
        sent         = 0;
        beats        = 0;
        gap          = 0;
        held         = 1'b0;
        expect_valid = 1'b0;
        while (sent < n_blocks || beats < n_beats) begin
            @(negedge clk);
            in_valid  = (sent < n_blocks) && (gap == 0);
            in_block  = block_of(sent);
            out_ready = (beats < n_beats) && (!rand_ready || (($random(seed) & 1) == 0));
            if (gap > 0) begin
                gap--;
            end
            @(posedge clk);
            in_acc  = in_valid && in_ready;
            out_acc = out_valid && out_ready;
            bend    = 1'b0;
            assert (!(unread >= NBlocks && in_ready))
                else fail_run("in_ready_o was high while four unread blocks were stored");
            assert (!(blocks_left == 0 && in_ready))
                else fail_run("in_ready_o was high after the final block of the pass");
            if (expect_valid) begin
                assert (out_valid) else fail_run("out_valid_o did not rise after a block arrived");
            end
            if (held) begin
                assert (out_valid && out_elem == held_elem)
                    else fail_run("a stalled output beat changed before it was taken");
            end
            if (out_acc) begin
                assert (out_elem == exp_elem[0]) else fail_run($sformatf(
                    "Mismatch out_elem_o: got %h, expected %h", out_elem, exp_elem[0]));
                assert (out_last == exp_last[0]) else fail_run($sformatf(
                    "Mismatch out_last_o: got %h, expected %h", out_last, exp_last[0]));
                bend = exp_bend.pop_front();
                void'(exp_elem.pop_front());
                void'(exp_last.pop_front());
                beats++;
            end
            expect_valid = in_acc && (unread == 0);
            held         = out_valid && !out_ready;
            held_elem    = out_elem;
            unread       = unread + int'(in_acc) - int'(out_acc && bend);
            if (in_acc) begin
                sent++;
                blocks_left--;
                gap = rand_gap ? ($random(seed) & 3) : 0;
            end
        end
    endtask

    task automatic check_idle(input string when_s);
        assert (in_ready) else fail_run($sformatf(
            "Mismatch in_ready_o after %s: got %h, expected 1", when_s, in_ready));
        assert (!out_valid) else fail_run($sformatf(
            "Mismatch out_valid_o after %s: got %h, expected 0", when_s, out_valid));
        assert (!out_last) else fail_run($sformatf(
            "Mismatch out_last_o after %s: got %h, expected 0", when_s, out_last));
    endtask

    task automatic apply_clear();
        @(negedge clk);
        clear     = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        @(negedge clk);
        clear = 1'b0;
        exp_elem.delete();
        exp_last.delete();
        exp_bend.delete();
        unread      = 0;
        blocks_left = 0;
        check_idle("clear");
    endtask

    task automatic start_pass(input int nb, input int lo, input logic [3:0] tag);
        num_blocks  = rb_pkg::blk_cnt_t'(nb);
        leftover    = rb_pkg::elem_ptr_t'(lo);
        data_tag    = tag;
        blocks_left = nb + 1;
        add_pass(nb, lo, 1'b0);
    endtask

    task automatic test_reset_and_clear();
        check_idle("reset");
        apply_clear();
    endtask

    task automatic test_single_pass();
        start_pass(2, 2, 4'h1);
        run_traffic(3, pass_beats(2, 2), 1'b0, 1'b0);
    endtask

    task automatic test_reuse_passes();
        add_pass(2, 2, 1'b1);
        add_pass(2, 2, 1'b0);
        add_pass(2, 2, 1'b1);
        run_traffic(0, 3 * pass_beats(2, 2), 1'b0, 1'b0);
    endtask

    task automatic test_back_pressure();
        add_pass(2, 2, 1'b0);
        add_pass(2, 2, 1'b1);
        run_traffic(0, 2 * pass_beats(2, 2), 1'b0, 1'b1);
    endtask

    task automatic test_long_pass();
        apply_clear();
        start_pass(6, 1, 4'h2);
        run_traffic(7, pass_beats(6, 1), 1'b1, 1'b0);
    endtask

    task automatic test_clear_mid_pass();
        apply_clear();
        start_pass(4, 1, 4'h3);
        run_traffic(3, 10, 1'b0, 1'b0);
        apply_clear();
        start_pass(1, 3, 4'h4);
        add_pass(1, 3, 1'b1);
        run_traffic(2, 2 * pass_beats(1, 3), 1'b0, 1'b0);
    endtask

    initial begin
        seed        = 32'hd249;
        clear       = 1'b0;
        num_blocks  = '0;
        leftover    = '0;
        in_valid    = 1'b0;
        in_block    = '0;
        out_ready   = 1'b0;
        unread      = 0;
        blocks_left = 0;
        data_tag    = 4'h0;
        wait (rst_n === 1'b1);
        test_reset_and_clear();
        test_single_pass();
        test_reuse_passes();
        test_back_pressure();
        test_long_pass();
        test_clear_mid_pass();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hw
hw/rb_pkg.sv
hw/rb_ctrl.sv
hw/rb_block_ptrs.sv
hw/rb_elem_seq.sv
hw/rb_block_store.sv
hw/reuse_buffer.sv
dv/tb_clk_gen.sv
dv/tb_reuse_buffer.sv

// File: hw/rb_block_ptrs.sv
`timescale 1ns/1ps
`include "rb_config.svh"

module rb_block_ptrs (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               wr_en_i,
    input  logic               rd_step_i,
    input  rb_pkg::dir_e       dir_i,
    input  logic               pass_restart_i,
    input  rb_pkg::blk_cnt_t   num_blocks_i,
    output rb_pkg::blk_ptr_t   wr_ptr_o,
    output rb_pkg::blk_ptr_t   rd_ptr_o,
    output logic               full_next_o,
    output logic               empty_next_o,
    output logic               write_done_o,
    output logic               reuse_all_o,
    output logic               ptrs_meet_o
);

    localparam int unsigned PtrW = $clog2(`RB_N_BLOCKS);

    rb_pkg::blk_ptr_t wr_ptr_q, rd_ptr_q, wr_next, rd_next, last_blk_ptr;
    rb_pkg::blk_cnt_t pass_cnt_q, rounds_read, rounds_total, round_last;
    logic             fwd, last_round;

    assign fwd = (dir_i == rb_pkg::FORWARD);

    // the depth is a power of two, so the pointers wrap by overflow.
    assign wr_next = fwd ? wr_ptr_q + rb_pkg::blk_ptr_t'(1) : wr_ptr_q - rb_pkg::blk_ptr_t'(1);
    assign rd_next = fwd ? rd_ptr_q + rb_pkg::blk_ptr_t'(1) : rd_ptr_q - rb_pkg::blk_ptr_t'(1);

    assign full_next_o  = (wr_next == rd_ptr_q);
    assign empty_next_o = (rd_next == wr_ptr_q);
    assign ptrs_meet_o  = (wr_ptr_q == rd_ptr_q);

    // storage rounds read so far against the rounds the pass needs.
    assign rounds_read  = pass_cnt_q >> PtrW;
    assign rounds_total = num_blocks_i >> PtrW;
    assign round_last   = rounds_total - rb_pkg::blk_cnt_t'(1);
    assign last_blk_ptr = num_blocks_i[PtrW-1:0];

    assign last_round = ((rounds_read == round_last) && (rd_ptr_q > last_blk_ptr))
                      || (rounds_read == rounds_total);

    assign write_done_o = last_round && (wr_ptr_q == (fwd ? last_blk_ptr : '0));
    assign reuse_all_o  = (rounds_read == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
        end else if (pass_restart_i) begin
            if (reuse_all_o) begin
                wr_ptr_q <= fwd ? '0 : last_blk_ptr;   // the reverse pass ends where this began.
            end
        end else if (wr_en_i && !write_done_o) begin
            wr_ptr_q <= wr_next;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q   <= '0;
            pass_cnt_q <= '0;
        end else if (clear_i) begin
            rd_ptr_q   <= '0;
            pass_cnt_q <= '0;
        end else if (pass_restart_i) begin
            pass_cnt_q <= '0;
        end else if (rd_step_i) begin
            rd_ptr_q   <= rd_next;
            pass_cnt_q <= pass_cnt_q + rb_pkg::blk_cnt_t'(1);
        end
    end

    assign wr_ptr_o = wr_ptr_q;
    assign rd_ptr_o = rd_ptr_q;

    // a write into the last free slot leaves the controller unable to write next cycle.
    a_no_write_past_full : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        (wr_en_i && full_next_o && !rd_step_i) |=> !wr_en_i);

endmodule

// File: hw/rb_block_store.sv
`timescale 1ns/1ps
`include "rb_config.svh"

module rb_block_store (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                wr_en_i,
    input  rb_pkg::blk_ptr_t    wr_ptr_i,
    input  rb_pkg::block_t      block_i,
    input  rb_pkg::blk_ptr_t    rd_ptr_i,
    input  rb_pkg::elem_ptr_t   elem_ptr_i,
    output rb_pkg::elem_t       elem_o
);

    rb_pkg::block_t blocks_q [`RB_N_BLOCKS];
    rb_pkg::block_t rd_block;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `RB_N_BLOCKS; i++) begin
                blocks_q[i] <= '0;
            end
        end else if (clear_i) begin
            for (int i = 0; i < `RB_N_BLOCKS; i++) begin
                blocks_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            blocks_q[wr_ptr_i] <= block_i;
        end
    end

    // read side is combinational.
    assign rd_block = blocks_q[rd_ptr_i];
    assign elem_o   = rd_block[elem_ptr_i*`RB_ELEM_W +: `RB_ELEM_W];

endmodule

// File: hw/rb_config.svh
`ifndef RB_CONFIG_SVH
`define RB_CONFIG_SVH

// width of one element in bits.
`define RB_ELEM_W 16

// elements carried by one upstream block.
`define RB_N_ELEMS 4

// blocks held in storage. This must be a power of two.
`define RB_N_BLOCKS 4

// times each element is presented before the read moves on.
`define RB_ELEM_READS 2

// width of the block count of one pass.
`define RB_CNT_W 8

`endif

// File: hw/rb_ctrl.sv
`timescale 1ns/1ps

module rb_ctrl (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           clear_i,
    input  logic           in_valid_i,
    input  logic           out_ready_i,
    input  logic           full_next_i,
    input  logic           empty_next_i,
    input  logic           write_done_i,
    input  logic           reuse_all_i,
    input  logic           block_end_i,
    input  logic           pass_end_i,
    output logic           in_ready_o,
    output logic           out_valid_o,
    output logic           in_bounce_o,
    output logic           wr_en_o,
    output logic           rd_step_o,
    output rb_pkg::dir_e   dir_o,
    output logic           pass_restart_o
);

    rb_pkg::state_e state_q, state_d;
    rb_pkg::dir_e   dir_q;
    logic           blk_read;

    assign blk_read = out_ready_i & block_end_i;   // last beat of a block leaves.

    // ************************************************************************
    // next state and handshake
    // ************************************************************************
    always_comb begin
        state_d        = state_q;
        in_ready_o     = 1'b0;
        out_valid_o    = 1'b0;
        wr_en_o        = 1'b0;
        rd_step_o      = 1'b0;
        pass_restart_o = 1'b0;

        case (state_q)
            rb_pkg::EMPTY: begin
                in_ready_o = 1'b1;
                wr_en_o    = in_valid_i;
                if (in_valid_i) begin
                    state_d = write_done_i ? rb_pkg::BOUNCE : rb_pkg::MIDDLE;
                end
            end
            rb_pkg::MIDDLE: begin
                in_ready_o  = 1'b1;
                out_valid_o = 1'b1;
                wr_en_o     = in_valid_i;
                rd_step_o   = blk_read;
                if (in_valid_i) begin
                    if (write_done_i) begin
                        state_d = rb_pkg::BOUNCE;
                    end else if (full_next_i && !blk_read) begin
                        state_d = rb_pkg::FULL;   // this write takes the last free slot.
                    end
                end else if (blk_read && empty_next_i) begin
                    state_d = rb_pkg::EMPTY;
                end
            end
            rb_pkg::FULL: begin
                out_valid_o = 1'b1;
                rd_step_o   = blk_read;
                if (blk_read) begin
                    state_d = rb_pkg::MIDDLE;
                end
            end
            rb_pkg::BOUNCE: begin
                out_valid_o = 1'b1;
                // the final beat of a pass turns around instead of stepping the block.
                if (out_ready_i && pass_end_i) begin
                    pass_restart_o = 1'b1;
                    state_d        = reuse_all_i ? rb_pkg::BOUNCE : rb_pkg::FULL;
                end else begin
                    rd_step_o = blk_read;
                end
            end
            default: begin
                state_d = rb_pkg::EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= rb_pkg::EMPTY;
            dir_q   <= rb_pkg::FORWARD;
        end else if (clear_i) begin
            state_q <= rb_pkg::EMPTY;
            dir_q   <= rb_pkg::FORWARD;
        end else begin
            state_q <= state_d;
            if (pass_restart_o) begin
                dir_q <= (dir_q == rb_pkg::FORWARD) ? rb_pkg::BACKWARD : rb_pkg::FORWARD;
            end
        end
    end

    assign dir_o       = dir_q;
    assign in_bounce_o = (state_q == rb_pkg::BOUNCE);

    // the final block of a pass closes the input for the replay.
    a_no_ready_after_last_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wr_en_o && write_done_i && !clear_i) |=> !in_ready_o);

    // valid rises only after a block was written.
    a_no_valid_without_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!out_valid_o && !wr_en_o) |=> !out_valid_o);

endmodule

// File: hw/rb_elem_seq.sv
`timescale 1ns/1ps
`include "rb_config.svh"

module rb_elem_seq (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                beat_i,
    input  rb_pkg::dir_e        dir_i,
    input  logic                ptrs_meet_i,
    input  logic                in_bounce_i,
    input  rb_pkg::elem_ptr_t   leftover_i,
    output rb_pkg::elem_ptr_t   elem_ptr_o,
    output logic                elem_step_done_o,
    output logic                block_end_o,
    output logic                pass_end_o,
    output logic                last_o
);

    localparam rb_pkg::elem_ptr_t ElemLast = rb_pkg::elem_ptr_t'(`RB_N_ELEMS - 1);
    localparam rb_pkg::rpt_cnt_t  RptLast  = rb_pkg::rpt_cnt_t'(`RB_ELEM_READS - 1);

    rb_pkg::elem_ptr_t elem_q, elem_next;
    rb_pkg::rpt_cnt_t  rpt_q;
    logic              fwd, at_edge;

    assign fwd     = (dir_i == rb_pkg::FORWARD);
    assign at_edge = fwd ? (elem_q == ElemLast) : (elem_q == '0);   // block boundary ahead.

    always_comb begin
        if (at_edge) begin
            elem_next = fwd ? '0 : ElemLast;
        end else begin
            elem_next = fwd ? elem_q + rb_pkg::elem_ptr_t'(1) : elem_q - rb_pkg::elem_ptr_t'(1);
        end
    end

    // the final element sits at leftover going forward and at zero going back.
    assign last_o = in_bounce_i && ptrs_meet_i && (elem_q == (fwd ? leftover_i : '0));

    assign elem_step_done_o = (rpt_q == RptLast);
    assign block_end_o      = elem_step_done_o && at_edge;
    assign pass_end_o       = elem_step_done_o && last_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rpt_q  <= '0;
            elem_q <= '0;
        end else if (clear_i) begin
            rpt_q  <= '0;
            elem_q <= '0;
        end else if (beat_i) begin
            rpt_q <= elem_step_done_o ? '0 : rpt_q + rb_pkg::rpt_cnt_t'(1);
            if (elem_step_done_o && !pass_end_o) begin
                elem_q <= elem_next;   // holds at a pass end, the turn starts on it.
            end
        end
    end

    assign elem_ptr_o = elem_q;

endmodule

// File: hw/rb_pkg.sv
`include "rb_config.svh"

package rb_pkg;

    typedef logic [`RB_ELEM_W-1:0]                elem_t;
    typedef logic [`RB_N_ELEMS*`RB_ELEM_W-1:0]    block_t;   // element 0 in the low bits.
    typedef logic [$clog2(`RB_N_BLOCKS)-1:0]      blk_ptr_t;
    typedef logic [$clog2(`RB_N_ELEMS)-1:0]       elem_ptr_t;
    typedef logic [`RB_CNT_W-1:0]                 blk_cnt_t;
    typedef logic [$clog2(`RB_ELEM_READS)-1:0]    rpt_cnt_t;

    // controller states, by how much unread data the store holds.
    typedef enum logic [1:0] {
        EMPTY,
        MIDDLE,
        FULL,
        BOUNCE
    } state_e;

    typedef enum logic {
        FORWARD,
        BACKWARD
    } dir_e;

endpackage

// File: hw/reuse_buffer.sv
`timescale 1ns/1ps

module reuse_buffer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  rb_pkg::blk_cnt_t    num_blocks_i,
    input  rb_pkg::elem_ptr_t   leftover_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  rb_pkg::block_t      in_block_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output rb_pkg::elem_t       out_elem_o,
    output logic                out_last_o
);

    // ************************************************************************
    // control and datapath wiring
    // ************************************************************************
    logic              wr_en, rd_step, pass_restart, in_bounce, beat;
    logic              full_next, empty_next, write_done, reuse_all, ptrs_meet;
    logic              block_end, pass_end;
    rb_pkg::dir_e      dir;
    rb_pkg::blk_ptr_t  wr_ptr, rd_ptr;
    rb_pkg::elem_ptr_t elem_ptr;

    assign beat = out_valid_o & out_ready_i;

    rb_ctrl i_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .in_valid_i     (in_valid_i),
        .out_ready_i    (out_ready_i),
        .full_next_i    (full_next),
        .empty_next_i   (empty_next),
        .write_done_i   (write_done),
        .reuse_all_i    (reuse_all),
        .block_end_i    (block_end),
        .pass_end_i     (pass_end),
        .in_ready_o     (in_ready_o),
        .out_valid_o    (out_valid_o),
        .in_bounce_o    (in_bounce),
        .wr_en_o        (wr_en),
        .rd_step_o      (rd_step),
        .dir_o          (dir),
        .pass_restart_o (pass_restart)
    );

    rb_block_ptrs i_block_ptrs (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .wr_en_i        (wr_en),
        .rd_step_i      (rd_step),
        .dir_i          (dir),
        .pass_restart_i (pass_restart),
        .num_blocks_i   (num_blocks_i),
        .wr_ptr_o       (wr_ptr),
        .rd_ptr_o       (rd_ptr),
        .full_next_o    (full_next),
        .empty_next_o   (empty_next),
        .write_done_o   (write_done),
        .reuse_all_o    (reuse_all),
        .ptrs_meet_o    (ptrs_meet)
    );

    rb_elem_seq i_elem_seq (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .clear_i          (clear_i),
        .beat_i           (beat),
        .dir_i            (dir),
        .ptrs_meet_i      (ptrs_meet),
        .in_bounce_i      (in_bounce),
        .leftover_i       (leftover_i),
        .elem_ptr_o       (elem_ptr),
        .elem_step_done_o (),
        .block_end_o      (block_end),
        .pass_end_o       (pass_end),
        .last_o           (out_last_o)
    );

    rb_block_store i_block_store (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (clear_i),
        .wr_en_i    (wr_en),
        .wr_ptr_i   (wr_ptr),
        .block_i    (in_block_i),
        .rd_ptr_i   (rd_ptr),
        .elem_ptr_i (elem_ptr),
        .elem_o     (out_elem_o)
    );

endmodule
